/* include/ex_settings.svh */
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// width of one datapath word
`define DATA_W 32

// one quotient bit per divider iteration
`define DIV_ITER 32

// fall-through and link increment
`define PC_STEP 4

`endif

/* design/isa_pkg.sv */
`include "ex_settings.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0] bus32_t;

    typedef enum logic [4:0] {
        NOP,
        ADD_W,
        SUB_W,
        SLT,
        SLTU,
        AND,
        OR,
        XOR,
        NOR,
        SLL_W,
        SRL_W,
        SRA_W,
        LU12I,
        PCADDU12I,
        DIV_W,
        MOD_W,
        DIV_WU,
        MOD_WU,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        B,
        BL,
        JIRL
    } alu_op_e;

    // which unit produces the write-back value
    typedef enum logic [2:0] {
        LOGIC,
        SHIFT,
        ARITH,
        DIV,
        JUMP_BRANCH,
        NONE
    } alu_sel_e;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    import isa_pkg::*;

    typedef struct packed {
        bus32_t            pc;
        bus32_t            inst;
        logic              inst_valid;
        logic              is_privilege;
        alu_op_e           aluop;
        alu_sel_e          alusel;
        bus32_t [1:0]      reg_data;
        logic              reg_write_en;
        logic [4:0]        reg_write_addr;
        logic              is_exception;
        logic [5:0]        exception_cause;
        logic              pre_is_branch_taken;
        bus32_t            pre_branch_addr;
    } dispatch_ex_t;

    typedef struct packed {
        bus32_t            pc;
        bus32_t            inst;
        logic              inst_valid;
        logic              is_privilege;
        alu_op_e           aluop;
        logic              is_exception;
        logic [5:0]        exception_cause;
        logic              reg_write_en;
        logic [4:0]        reg_write_addr;
        bus32_t            reg_write_data;
        bus32_t            mem_addr;
        bus32_t            csr_addr;
        logic              csr_write_en;
        bus32_t            csr_write_data;
        logic              is_llw_scw;
    } ex_mem_t;

    // report back to the branch predictor
    typedef struct packed {
        logic              update_en;
        bus32_t            pc;
        logic              is_branch;
        logic              is_taken;
        bus32_t            branch_actual_addr;
    } branch_update_t;

endpackage

/* design/regular_alu.sv */
module regular_alu
    import isa_pkg::*;
(
    input  alu_op_e aluop_i,
    input  bus32_t  reg1_i,
    input  bus32_t  reg2_i,
    output bus32_t  result_o
);

    logic [4:0] shamt;

    assign shamt = reg2_i[4:0];

    always_comb begin
        case (aluop_i)
            ADD_W: begin
                result_o = reg1_i + reg2_i;
            end
            SUB_W: begin
                result_o = reg1_i - reg2_i;
            end
            SLT: begin
                result_o = bus32_t'($signed(reg1_i) < $signed(reg2_i));
            end
            SLTU: begin
                result_o = bus32_t'(reg1_i < reg2_i);
            end
            AND: begin
                result_o = reg1_i & reg2_i;
            end
            OR: begin
                result_o = reg1_i | reg2_i;
            end
            XOR: begin
                result_o = reg1_i ^ reg2_i;
            end
            NOR: begin
                result_o = ~(reg1_i | reg2_i);
            end
            SLL_W: begin
                result_o = reg1_i << shamt;
            end
            SRL_W: begin
                result_o = reg1_i >> shamt;
            end
            SRA_W: begin
                result_o = bus32_t'($signed(reg1_i) >>> shamt);
            end
            // immediate arrives already shifted into the upper bits
            LU12I: begin
                result_o = reg2_i;
            end
            PCADDU12I: begin
                result_o = reg1_i + reg2_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* design/div_alu.sv */
`include "ex_settings.svh"

module div_alu
    import isa_pkg::*;
(
    input  logic   clk,
    input  logic   reset_i,
    input  logic   signed_i,
    input  bus32_t dividend_i,
    input  bus32_t divisor_i,
    input  logic   start_i,
    output bus32_t quotient_o,
    output bus32_t remainder_o,
    output logic   done_o
);

    localparam int CNT_W = $clog2(`DIV_ITER);

    typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_e;

    div_state_e       state_q;
    logic [CNT_W-1:0] iter_q;

    bus32_t           quo_q;
    bus32_t           rem_q;
    bus32_t           dvs_q;
    bus32_t           dividend_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             zero_div_q;

    logic             dvd_neg;
    logic             dvs_neg;
    bus32_t           dvd_abs;
    bus32_t           dvs_abs;
    logic [`DATA_W:0] trial;
    logic             fits;

    assign dvd_neg = signed_i & dividend_i[`DATA_W-1];
    assign dvs_neg = signed_i & divisor_i[`DATA_W-1];
    assign dvd_abs = dvd_neg ? -dividend_i : dividend_i;
    assign dvs_abs = dvs_neg ? -divisor_i : divisor_i;

    // shift in the next dividend bit and try the subtract
    assign trial = {rem_q, quo_q[`DATA_W-1]};
    assign fits  = trial >= {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= IDLE;
            iter_q  <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= RUN;
                        iter_q  <= '0;
                    end
                end
                RUN: begin
                    iter_q <= iter_q + 1'b1;
                    if (iter_q == CNT_W'(`DIV_ITER - 1)) begin
                        state_q <= DONE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            quo_q      <= dvd_abs;
            rem_q      <= '0;
            dvs_q      <= dvs_abs;
            dividend_q <= dividend_i;
            neg_quo_q  <= dvd_neg ^ dvs_neg;
            neg_rem_q  <= dvd_neg;
            zero_div_q <= (divisor_i == '0);
        end else if (state_q == RUN) begin
            quo_q <= {quo_q[`DATA_W-2:0], fits};
            rem_q <= fits ? bus32_t'(trial - {1'b0, dvs_q}) : trial[`DATA_W-1:0];
        end
    end

    // remainder follows the dividend sign
    assign quotient_o  = zero_div_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign remainder_o = zero_div_q ? dividend_q : (neg_rem_q ? -rem_q : rem_q);
    assign done_o      = (state_q == DONE);

    assert property (@(posedge clk) disable iff (reset_i) done_o |=> !done_o);

    // the lane must keep the request steady until done
    assert property (@(posedge clk) disable iff (reset_i)
        (state_q == RUN) |-> start_i && $stable(signed_i));

endmodule

/* design/branch_alu.sv */
`include "ex_settings.svh"

module branch_alu
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  bus32_t         pc_i,
    input  bus32_t         inst_i,
    input  alu_op_e        aluop_i,
    input  bus32_t         reg1_i,
    input  bus32_t         reg2_i,
    input  logic           pre_taken_i,
    input  bus32_t         pre_addr_i,
    output branch_update_t update_info_o,
    output logic           branch_flush_o,
    output bus32_t         link_o
);

    logic   is_branch;
    logic   taken;
    bus32_t offs16;
    bus32_t offs26;
    bus32_t target;
    bus32_t actual_addr;

    always_comb begin
        is_branch = 1'b1;
        taken     = 1'b0;
        case (aluop_i)
            BEQ:         taken = (reg1_i == reg2_i);
            BNE:         taken = (reg1_i != reg2_i);
            BLT:         taken = ($signed(reg1_i) < $signed(reg2_i));
            BGE:         taken = ($signed(reg1_i) >= $signed(reg2_i));
            BLTU:        taken = (reg1_i < reg2_i);
            BGEU:        taken = (reg1_i >= reg2_i);
            B, BL, JIRL: taken = 1'b1;
            default:     is_branch = 1'b0;
        endcase
    end

    // offs26 keeps its upper ten bits in inst[9:0]
    assign offs16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign offs26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    always_comb begin
        if (aluop_i == JIRL) begin
            target = reg1_i + offs16;
        end else if (aluop_i == B || aluop_i == BL) begin
            target = pc_i + offs26;
        end else begin
            target = pc_i + offs16;
        end
    end

    assign link_o      = pc_i + bus32_t'(`PC_STEP);
    assign actual_addr = taken ? target : link_o;

    always_comb begin
        update_info_o.update_en          = is_branch;
        update_info_o.pc                 = pc_i;
        update_info_o.is_branch          = is_branch;
        update_info_o.is_taken           = taken;
        update_info_o.branch_actual_addr = actual_addr;
    end

    assign branch_flush_o = is_branch && (taken != pre_taken_i || actual_addr != pre_addr_i);

endmodule

/* design/deputy_ex.sv */
module deputy_ex
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic           clk,
    input  logic           reset_i,
    input  dispatch_ex_t   ex_i,
    output branch_update_t update_info_o,
    output logic           pause_alu_o,
    output logic           branch_flush_o,
    output bus32_t         branch_target_o,
    output ex_mem_t        ex_o
);

    bus32_t reg1;
    bus32_t regular_res;

    // pcaddu12i works on the pc instead of rj
    assign reg1 = (ex_i.aluop == PCADDU12I) ? ex_i.pc : ex_i.reg_data[0];

    regular_alu u_regular_alu (
        .aluop_i  (ex_i.aluop),
        .reg1_i   (reg1),
        .reg2_i   (ex_i.reg_data[1]),
        .result_o (regular_res)
    );

    logic   is_div;
    logic   is_mod;
    logic   div_signed;
    logic   start_div;
    logic   div_done;
    bus32_t quotient;
    bus32_t remainder;
    bus32_t div_res;

    assign is_div     = ex_i.aluop inside {DIV_W, MOD_W, DIV_WU, MOD_WU};
    assign is_mod     = ex_i.aluop inside {MOD_W, MOD_WU};
    assign div_signed = ex_i.aluop inside {DIV_W, MOD_W};
    assign start_div  = is_div && !div_done;

    div_alu u_div_alu (
        .clk,
        .reset_i,
        .signed_i    (div_signed),
        .dividend_i  (ex_i.reg_data[0]),
        .divisor_i   (ex_i.reg_data[1]),
        .start_i     (start_div),
        .quotient_o  (quotient),
        .remainder_o (remainder),
        .done_o      (div_done)
    );

    assign div_res = div_done ? (is_mod ? remainder : quotient) : '0;

    bus32_t link;

    branch_alu u_branch_alu (
        .pc_i           (ex_i.pc),
        .inst_i         (ex_i.inst),
        .aluop_i        (ex_i.aluop),
        .reg1_i         (ex_i.reg_data[0]),
        .reg2_i         (ex_i.reg_data[1]),
        .pre_taken_i    (ex_i.pre_is_branch_taken),
        .pre_addr_i     (ex_i.pre_branch_addr),
        .update_info_o  (update_info_o),
        .branch_flush_o (branch_flush_o),
        .link_o         (link)
    );

    assign branch_target_o = update_info_o.branch_actual_addr;
    assign pause_alu_o     = start_div;

    always_comb begin
        ex_o                 = '0;
        ex_o.pc              = ex_i.pc;
        ex_o.inst            = ex_i.inst;
        ex_o.inst_valid      = ex_i.inst_valid;
        ex_o.is_privilege    = ex_i.is_privilege;
        ex_o.aluop           = ex_i.aluop;
        ex_o.is_exception    = ex_i.is_exception;
        ex_o.exception_cause = ex_i.exception_cause;
        ex_o.reg_write_en    = ex_i.reg_write_en;
        ex_o.reg_write_addr  = ex_i.reg_write_addr;
        case (ex_i.alusel)
            LOGIC, SHIFT, ARITH: ex_o.reg_write_data = regular_res;
            DIV:                 ex_o.reg_write_data = div_res;
            JUMP_BRANCH:         ex_o.reg_write_data = link;
            default:             ex_o.reg_write_data = '0;
        endcase
    end

    // dispatch decode of alusel must agree with the div aluop
    assert property (@(posedge clk) disable iff (reset_i) pause_alu_o |-> ex_i.alusel == DIV);

endmodule

/* design/ex_mem_reg.sv */
module ex_mem_reg
    import pipe_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    pause_i,
    input  ex_mem_t ex_i,
    output ex_mem_t mem_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_o.inst_valid   <= 1'b0;
            mem_o.reg_write_en <= 1'b0;
        end else if (pause_i) begin
            // bubble while the divider runs
            mem_o <= '0;
        end else begin
            mem_o <= ex_i;
        end
    end

endmodule

/* design/ex_unit_top.sv */
module ex_unit_top
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic           clk,
    input  logic           reset_i,
    input  dispatch_ex_t   ex_i,
    output branch_update_t update_info_o,
    output logic           pause_o,
    output logic           branch_flush_o,
    output bus32_t         branch_target_o,
    output ex_mem_t        mem_o
);

    ex_mem_t ex_res;

    deputy_ex u_deputy_ex (
        .clk,
        .reset_i,
        .ex_i,
        .update_info_o,
        .pause_alu_o     (pause_o),
        .branch_flush_o,
        .branch_target_o,
        .ex_o            (ex_res)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk,
        .reset_i,
        .pause_i (pause_o),
        .ex_i    (ex_res),
        .mem_o
    );

endmodule

/* verif/tb_ex_unit.sv */
`include "ex_settings.svh"

module tb_ex_unit
    import isa_pkg::*;
    import pipe_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // regular, div, branch, jump, pass-through ops plus one idle op per test
    localparam int NUM_OPS = 13 * 6 + 4 * 6 + 6 * 8 + 3 * 6 + 8 + 6;

    logic           clk;
    logic           reset_i;
    dispatch_ex_t   ex_i;
    branch_update_t update_info_o;
    logic           pause_o;
    logic           branch_flush_o;
    bus32_t         branch_target_o;
    ex_mem_t        mem_o;

    int             seed = 15;
    int             errors = 0;
    int             tests_ok = 0;
    int             tests_bad = 0;

    alu_op_e        reg_ops[13] = '{ADD_W, SUB_W, SLT, SLTU, AND, OR, XOR, NOR,
                                    SLL_W, SRL_W, SRA_W, LU12I, PCADDU12I};
    alu_op_e        div_ops[4] = '{DIV_W, MOD_W, DIV_WU, MOD_WU};
    alu_op_e        cond_ops[6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    alu_op_e        jump_ops[3] = '{B, BL, JIRL};

    // expectations for the op on ex_i
    logic           wb_chk;
    bus32_t         wb_exp;
    logic           br_chk;
    logic           exp_flush;
    bus32_t         exp_target;
    branch_update_t exp_upd;
    logic           div_act;

    // expectations for the op now held in mem_o
    logic           acc_vld_q;
    dispatch_ex_t   acc_q;
    logic           wb_chk_q;
    bus32_t         wb_exp_q;
    logic           rst_q = 1'b0;
    int             pause_run = 0;

    ex_unit_top dut0 (
        .clk,
        .reset_i,
        .ex_i,
        .update_info_o,
        .pause_o,
        .branch_flush_o,
        .branch_target_o,
        .mem_o
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        repeat (NUM_OPS * (`DIV_ITER + 4) + 50) @(posedge clk);
        $display("timeout: the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

    always @(posedge clk) begin
        rst_q     <= reset_i;
        pause_run <= pause_o ? pause_run + 1 : 0;
        if (reset_i) begin
            acc_vld_q <= 1'b0;
            wb_chk_q  <= 1'b0;
        end else begin
            acc_vld_q <= !pause_o;
            wb_chk_q  <= wb_chk && !pause_o;
            acc_q     <= ex_i;
            wb_exp_q  <= wb_exp;
        end
    end

    assert property (@(posedge clk) (rst_q && !reset_i) |->
        !mem_o.inst_valid && !mem_o.reg_write_en && !pause_o)
    else begin
        $display("** Error mem_o.inst_valid/reg_write_en/pause_o: expected 0 0 0, got %h %h %h",
            $sampled(mem_o.inst_valid), $sampled(mem_o.reg_write_en), $sampled(pause_o));
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        wb_chk_q |-> mem_o.reg_write_data == wb_exp_q)
    else begin
        $display("** Error mem_o.reg_write_data: expected %h, got %h",
            $sampled(wb_exp_q), $sampled(mem_o.reg_write_data));
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        acc_vld_q |-> mem_o.pc == acc_q.pc && mem_o.inst == acc_q.inst)
    else begin
        $display("** Error mem_o.pc/inst: expected %h %h, got %h %h", $sampled(acc_q.pc),
            $sampled(acc_q.inst), $sampled(mem_o.pc), $sampled(mem_o.inst));
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i) acc_vld_q |->
        {mem_o.inst_valid, mem_o.is_privilege, mem_o.aluop, mem_o.reg_write_en,
         mem_o.reg_write_addr, mem_o.is_exception, mem_o.exception_cause} ==
        {acc_q.inst_valid, acc_q.is_privilege, acc_q.aluop, acc_q.reg_write_en,
         acc_q.reg_write_addr, acc_q.is_exception, acc_q.exception_cause})
    else begin
        $display("** Error mem_o control fields: expected addr %h cause %h, got addr %h cause %h",
            $sampled(acc_q.reg_write_addr), $sampled(acc_q.exception_cause),
            $sampled(mem_o.reg_write_addr), $sampled(mem_o.exception_cause));
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i) acc_vld_q |->
        {mem_o.mem_addr, mem_o.csr_addr, mem_o.csr_write_en, mem_o.csr_write_data,
         mem_o.is_llw_scw} == '0)
    else begin
        $display("** Error mem_o.mem_addr/csr_addr: expected 0, got %h %h",
            $sampled(mem_o.mem_addr), $sampled(mem_o.csr_addr));
        errors++;
    end

    // a paused cycle must leave a bubble behind
    assert property (@(posedge clk) disable iff (reset_i)
        pause_o |=> !mem_o.inst_valid && !mem_o.reg_write_en)
    else begin
        $display("** Error mem_o.inst_valid/reg_write_en during pause: expected 0, got %h %h",
            $sampled(mem_o.inst_valid), $sampled(mem_o.reg_write_en));
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i) pause_o |-> div_act)
    else begin
        $display("pause_o went high while no division was presented");
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        (div_act && !pause_o) |-> pause_run == `DIV_ITER + 1)
    else begin
        $display("division finished after %0d paused cycles instead of %0d",
            $sampled(pause_run), `DIV_ITER + 1);
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        br_chk |-> branch_flush_o == exp_flush && branch_target_o == exp_target)
    else begin
        $display("** Error branch_flush_o/branch_target_o: expected %h %h, got %h %h",
            $sampled(exp_flush), $sampled(exp_target), $sampled(branch_flush_o),
            $sampled(branch_target_o));
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i) br_chk |-> update_info_o == exp_upd)
    else begin
        $display("** Error update_info_o: expected %h, got %h",
            $sampled(exp_upd), $sampled(update_info_o));
        errors++;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        !br_chk |-> !update_info_o.update_en && !branch_flush_o)
    else begin
        $display("branch update or flush raised for an op that is not a branch");
        errors++;
    end

    function automatic bus32_t rnd();
        return $random(seed);
    endfunction

    function automatic bus32_t regular_model(input alu_op_e op, input bus32_t a,
                                             input bus32_t b, input bus32_t pc);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ADD_W:     return a + b;
            SUB_W:     return a - b;
            SLT:       return {31'd0, $signed(a) < $signed(b)};
            SLTU:      return {31'd0, a < b};
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            NOR:       return ~(a | b);
            SLL_W:     return a << sh;
            SRL_W:     return a >> sh;
            SRA_W:     return $unsigned($signed(a) >>> sh);
            LU12I:     return b;
            PCADDU12I: return pc + b;
            default:   return '0;
        endcase
    endfunction

    function automatic bus32_t div_model(input alu_op_e op, input bus32_t a, input bus32_t b);
        logic want_rem;
        want_rem = (op == MOD_W || op == MOD_WU);
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        if (op == DIV_WU || op == MOD_WU) begin
            return want_rem ? a % b : a / b;
        end
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return want_rem ? '0 : 32'h8000_0000;
        end
        return want_rem ? $unsigned($signed(a) % $signed(b)) : $unsigned($signed(a) / $signed(b));
    endfunction

    // taken bit on top, actual next pc below
    function automatic logic [`DATA_W:0] branch_outcome(input dispatch_ex_t d);
        bus32_t a;
        bus32_t b;
        bus32_t offs16;
        bus32_t offs26;
        bus32_t target;
        logic   taken;
        a      = d.reg_data[0];
        b      = d.reg_data[1];
        offs16 = {{14{d.inst[25]}}, d.inst[25:10], 2'b00};
        offs26 = {{4{d.inst[9]}}, d.inst[9:0], d.inst[25:10], 2'b00};
        case (d.aluop)
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = ($signed(a) < $signed(b));
            BGE:     taken = ($signed(a) >= $signed(b));
            BLTU:    taken = (a < b);
            BGEU:    taken = (a >= b);
            default: taken = 1'b1;
        endcase
        if (d.aluop == JIRL) begin
            target = a + offs16;
        end else if (d.aluop == B || d.aluop == BL) begin
            target = d.pc + offs26;
        end else begin
            target = d.pc + offs16;
        end
        return {taken, taken ? target : d.pc + bus32_t'(`PC_STEP)};
    endfunction

    function automatic void expect_branch();
        logic [`DATA_W:0] res;
        res                        = branch_outcome(ex_i);
        br_chk                     = 1'b1;
        exp_target                 = res[`DATA_W-1:0];
        exp_flush                  = (res[`DATA_W] != ex_i.pre_is_branch_taken) ||
                                     (res[`DATA_W-1:0] != ex_i.pre_branch_addr);
        exp_upd.update_en          = 1'b1;
        exp_upd.pc                 = ex_i.pc;
        exp_upd.is_branch          = 1'b1;
        exp_upd.is_taken           = res[`DATA_W];
        exp_upd.branch_actual_addr = res[`DATA_W-1:0];
        wb_chk                     = ex_i.aluop inside {B, BL, JIRL};
        wb_exp                     = ex_i.pc + bus32_t'(`PC_STEP);
    endfunction

    task automatic new_op(input alu_op_e op, input alu_sel_e sel, input logic wen);
        bus32_t r1;
        bus32_t r2;
        r1 = rnd();
        r2 = rnd();
        ex_i                 = '0;
        ex_i.pc              = {r1[31:2], 2'b00};
        ex_i.inst            = rnd();
        ex_i.inst_valid      = 1'b1;
        ex_i.is_privilege    = r2[0];
        ex_i.aluop           = op;
        ex_i.alusel          = sel;
        ex_i.reg_data[0]     = rnd();
        ex_i.reg_data[1]     = rnd();
        ex_i.reg_write_en    = wen;
        ex_i.reg_write_addr  = r2[12:8];
        ex_i.is_exception    = r2[1];
        ex_i.exception_cause = r2[7:2];
        wb_chk               = 1'b0;
        br_chk               = 1'b0;
        div_act              = 1'b0;
    endtask

    // hold ex_i until the lane takes it, then step 1 ns past the edge
    task automatic issue();
        @(negedge clk);
        while (pause_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name, input int errs_before);
        new_op(NOP, NONE, 1'b0);
        ex_i.inst_valid = 1'b0;
        issue();
        if (errors == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: FAILED with %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic test_regular();
        alu_sel_e sel;
        int       errs;
        errs = errors;
        foreach (reg_ops[i]) begin
            sel = (reg_ops[i] inside {AND, OR, XOR, NOR}) ? LOGIC :
                  (reg_ops[i] inside {SLL_W, SRL_W, SRA_W}) ? SHIFT : ARITH;
            for (int k = 0; k < 6; k++) begin
                new_op(reg_ops[i], sel, 1'b1);
                // equal operands hit the compare boundary
                if (k == 0) begin
                    ex_i.reg_data[1] = ex_i.reg_data[0];
                end
                if (reg_ops[i] inside {LU12I, PCADDU12I}) begin
                    ex_i.reg_data[1][11:0] = '0;
                end
                wb_chk = 1'b1;
                wb_exp = regular_model(reg_ops[i], ex_i.reg_data[0], ex_i.reg_data[1], ex_i.pc);
                issue();
            end
        end
        end_test("regular", errs);
    endtask

    task automatic test_div();
        int errs;
        errs = errors;
        foreach (div_ops[i]) begin
            for (int k = 0; k < 6; k++) begin
                new_op(div_ops[i], DIV, 1'b1);
                if (k == 1) begin
                    ex_i.reg_data[1] = ex_i.reg_data[1] >> 20;
                end
                if (k == 3) begin
                    ex_i.reg_data[1] = ex_i.reg_data[1] | 32'hffff_ff00;
                end
                if (k == 4) begin
                    ex_i.reg_data[1] = '0;
                end
                if (k == 5) begin
                    ex_i.reg_data[0] = 32'h8000_0000;
                    ex_i.reg_data[1] = 32'hffff_ffff;
                end
                div_act = 1'b1;
                wb_chk  = 1'b1;
                wb_exp  = div_model(div_ops[i], ex_i.reg_data[0], ex_i.reg_data[1]);
                issue();
            end
        end
        end_test("divide", errs);
    endtask

    task automatic test_branch();
        logic [`DATA_W:0] res;
        int               errs;
        errs = errors;
        foreach (cond_ops[i]) begin
            for (int k = 0; k < 8; k++) begin
                new_op(cond_ops[i], JUMP_BRANCH, 1'b0);
                case (k / 2)
                    0: ex_i.reg_data[1] = ex_i.reg_data[0];
                    1: begin
                        ex_i.reg_data[0] = ex_i.reg_data[0] & 32'h3fff_ffff;
                        ex_i.reg_data[1] = ex_i.reg_data[0] + 32'd1;
                    end
                    2: begin
                        ex_i.reg_data[1] = ex_i.reg_data[1] & 32'h3fff_ffff;
                        ex_i.reg_data[0] = ex_i.reg_data[1] + 32'd1;
                    end
                    // signed and unsigned order disagree here
                    default: begin
                        ex_i.reg_data[0] = ex_i.reg_data[0] | 32'h8000_0000;
                        ex_i.reg_data[1] = ex_i.reg_data[1] & 32'h7fff_ffff;
                    end
                endcase
                res = branch_outcome(ex_i);
                ex_i.pre_is_branch_taken = (k % 2 == 0) ? res[`DATA_W] : !res[`DATA_W];
                ex_i.pre_branch_addr     = (k % 2 == 0) ? res[`DATA_W-1:0] : rnd();
                expect_branch();
                issue();
            end
        end
        end_test("branch", errs);
    endtask

    task automatic test_jump();
        logic [`DATA_W:0] res;
        int               errs;
        errs = errors;
        foreach (jump_ops[i]) begin
            for (int k = 0; k < 6; k++) begin
                new_op(jump_ops[i], JUMP_BRANCH, jump_ops[i] != B);
                res = branch_outcome(ex_i);
                ex_i.pre_is_branch_taken = (k % 3 != 2);
                ex_i.pre_branch_addr     = (k % 3 == 0) ? res[`DATA_W-1:0] :
                                                          res[`DATA_W-1:0] + 32'd8;
                expect_branch();
                issue();
            end
        end
        end_test("jump", errs);
    endtask

    task automatic test_passthrough();
        int errs;
        errs = errors;
        for (int k = 0; k < 8; k++) begin
            new_op(NOP, NONE, k[0]);
            issue();
        end
        end_test("pass-through", errs);
    endtask

    initial begin
        reset_i    = 1'b1;
        ex_i       = '0;
        wb_chk     = 1'b0;
        wb_exp     = '0;
        br_chk     = 1'b0;
        exp_flush  = 1'b0;
        exp_target = '0;
        exp_upd    = '0;
        div_act    = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset_i = 1'b0;
        end_test("reset", errors);
        test_regular();
        test_div();
        test_branch();
        test_jump();
        test_passthrough();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
            tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/regular_alu.sv
design/div_alu.sv
design/branch_alu.sv
design/deputy_ex.sv
design/ex_mem_reg.sv
design/ex_unit_top.sv
verif/tb_ex_unit.sv

/* Makefile */
SIM   := verilator
FLAGS := --binary --timing --assert
TOP   := tb_ex_unit
FLIST := compile.f
PASS  := All checks passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
